/* logic/fxp_defines.svh */
`ifndef FXP_DEFINES_SVH
`define FXP_DEFINES_SVH

// Q8.8 word layout
`define FXP_WI 8
`define FXP_WF 8
`define FXP_W  16

`define APB_AW 8

// register map
`define REG_OPA    8'h00
`define REG_OPB    8'h04
`define REG_CTRL   8'h08
`define REG_RESULT 8'h0C
`define REG_STATUS 8'h10

// field positions in CTRL and STATUS
`define CTRL_OP_LSB    0
`define CTRL_ROUND_BIT 2
`define STAT_DONE_BIT  0
`define STAT_OVF_BIT   1

`endif

/* logic/fxp_pkg.sv */
`include "fxp_defines.svh"

package fxp_pkg;

    // ------------------------------------------------------------------------
    // fixed-point word
    // ------------------------------------------------------------------------

    // signed Q8.8, sign bit included in the integer part
    typedef logic signed [`FXP_W-1:0] fxp_t;

    // ------------------------------------------------------------------------
    // opcodes
    // ------------------------------------------------------------------------

    // encoding 3 is reserved and never issued
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fxp_opcode_e;

endpackage

/* logic/fxp_op_if.sv */
`timescale 1ns/100ps

// one issued operation, from the APB decode to the pipeline
interface fxp_op_if
    import fxp_pkg::*;
();

    // single-cycle pulse per operation
    logic        valid;
    fxp_opcode_e opcode;
    logic        round;
    fxp_t        opa;
    fxp_t        opb;

    modport issuer (
        output valid,
        output opcode,
        output round,
        output opa,
        output opb
    );

    modport worker (
        input valid,
        input opcode,
        input round,
        input opa,
        input opb
    );

    // the result block only needs to count issues
    modport tracker (
        input valid
    );

endinterface

/* logic/fxp_resize.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

// converts a signed in_wi.in_wf value down to Q8.8
// expects in_wi >= FXP_WI and in_wf >= FXP_WF
module fxp_resize #(
    parameter int in_wi = 9,
    parameter int in_wf = 8
) (
    input  logic [in_wi+in_wf-1:0] in,
    input  logic                   round,
    output logic signed [`FXP_W-1:0] out,
    output logic                   overflow
);

    // input integer bits with the output fraction bits
    localparam int kw = in_wi + `FXP_WF;

    localparam logic signed [`FXP_W-1:0] max_val = {1'b0, {(`FXP_W-1){1'b1}}};
    localparam logic signed [`FXP_W-1:0] min_val = {1'b1, {(`FXP_W-1){1'b0}}};

    logic signed [kw-1:0] kept;

    // ------------------------------------------------------------------------
    // fraction trim with optional round half up
    // ------------------------------------------------------------------------

    generate
        if (in_wf > `FXP_WF) begin : g_trim
            localparam int dw = in_wf - `FXP_WF;

            logic [kw-1:0] trunc;
            logic          at_max;

            always_comb begin
                trunc  = in[in_wi+in_wf-1:dw];
                at_max = (trunc == {1'b0, {(kw-1){1'b1}}});
                // first dropped bit decides, the largest positive value cannot step up
                if (round && in[dw-1] && !at_max)
                    kept = trunc + 1'b1;
                else
                    kept = trunc;
            end
        end else begin : g_exact
            // nothing to drop, so no rounding
            assign kept = in;
        end
    endgenerate

    // ------------------------------------------------------------------------
    // integer saturation
    // ------------------------------------------------------------------------

    always_comb begin
        overflow = 1'b0;
        out      = kept[`FXP_W-1:0];
        if (kept > max_val) begin
            out      = max_val;
            overflow = 1'b1;
        end else if (kept < min_val) begin
            out      = min_val;
            overflow = 1'b1;
        end
    end

endmodule

/* logic/fxp_apb_decode.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

module fxp_apb_decode
    import fxp_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    fxp_op_if.issuer          op,
    input  fxp_t              result,
    input  logic              done,
    input  logic              ovf_sticky,
    output logic              ovf_clear
);

    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic [1:0]  ctrl_op_field;
    logic        op_reserved;
    logic        ctrl_wr_ok;
    logic        issue_pend;
    fxp_t        opa_q;
    fxp_t        opb_q;
    fxp_opcode_e opcode_q;
    logic        round_q;

    function automatic logic [31:0] sext(input fxp_t v);
        return {{(32-`FXP_W){v[`FXP_W-1]}}, v};
    endfunction

    // ------------------------------------------------------------------------
    // access decode
    // ------------------------------------------------------------------------

    // zero wait states, transfer completes on every access phase
    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;

    always_comb begin
        case (paddr)
            `REG_OPA, `REG_OPB, `REG_CTRL, `REG_RESULT, `REG_STATUS: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    assign ctrl_op_field = pwdata[`CTRL_OP_LSB +: 2];
    assign op_reserved   = (ctrl_op_field == 2'd3);
    assign ctrl_wr_ok    = wr_en && (paddr == `REG_CTRL) && !op_reserved;

    // unmapped address, or a CTRL write carrying the reserved opcode
    assign pslverr = access &&
                     (!addr_hit || (pwrite && (paddr == `REG_CTRL) && op_reserved));

    assign ovf_clear = wr_en && (paddr == `REG_STATUS) && pwdata[`STAT_OVF_BIT];

    // ------------------------------------------------------------------------
    // registers and issue
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opa_q    <= '0;
            opb_q    <= '0;
            opcode_q <= OP_ADD;
            round_q  <= 1'b0;
        end else if (wr_en) begin
            if (paddr == `REG_OPA)
                opa_q <= pwdata[`FXP_W-1:0];
            if (paddr == `REG_OPB)
                opb_q <= pwdata[`FXP_W-1:0];
            if (ctrl_wr_ok) begin
                opcode_q <= fxp_opcode_e'(ctrl_op_field);
                round_q  <= pwdata[`CTRL_ROUND_BIT];
            end
        end
    end

    // valid follows one cycle after the CTRL write lands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_pend <= 1'b0;
            op.valid   <= 1'b0;
        end else begin
            issue_pend <= ctrl_wr_ok;
            op.valid   <= issue_pend;
        end
    end

    // operands stay put until the next APB write, at least two cycles away
    assign op.opcode = opcode_q;
    assign op.round  = round_q;
    assign op.opa    = opa_q;
    assign op.opb    = opb_q;

    // ------------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------------

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                `REG_OPA:    prdata = sext(opa_q);
                `REG_OPB:    prdata = sext(opb_q);
                `REG_RESULT: prdata = sext(result);
                `REG_CTRL: begin
                    prdata[`CTRL_OP_LSB +: 2] = opcode_q;
                    prdata[`CTRL_ROUND_BIT]   = round_q;
                end
                `REG_STATUS: begin
                    prdata[`STAT_DONE_BIT] = done;
                    prdata[`STAT_OVF_BIT]  = ovf_sticky;
                end
                default: prdata = '0;
            endcase
        end
    end

endmodule

/* logic/fxp_execute.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

module fxp_execute
    import fxp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    fxp_op_if.worker op,
    output logic     res_valid,
    output fxp_t     res_data,
    output logic     res_ovf
);

    localparam int sum_w  = `FXP_W + 1;
    localparam int prod_w = 2 * `FXP_W;

    logic signed [sum_w-1:0]  sum_c;
    logic signed [prod_w-1:0] prod_c;
    logic [prod_w-1:0]        raw_c;

    logic                     s1_valid;
    fxp_opcode_e              s1_opcode;
    logic                     s1_round;
    logic [prod_w-1:0]        s1_raw;

    fxp_t                     sum_out;
    logic                     sum_ovf;
    fxp_t                     prod_out;
    logic                     prod_ovf;

    // ------------------------------------------------------------------------
    // stage 1: exact result
    // ------------------------------------------------------------------------

    // one extra bit keeps the sum exact
    always_comb begin
        if (op.opcode == OP_SUB)
            sum_c = op.opa - op.opb;
        else
            sum_c = op.opa + op.opb;
        prod_c = op.opa * op.opb;
    end

    // sum and product share one register, the sum sign-extended
    assign raw_c = (op.opcode == OP_MUL) ? prod_c
                                         : {{(prod_w-sum_w){sum_c[sum_w-1]}}, sum_c};

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= op.valid;
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            s1_opcode <= op.opcode;
            s1_round  <= op.round;
            s1_raw    <= raw_c;
        end
    end

    // ------------------------------------------------------------------------
    // stage 2: resize to Q8.8
    // ------------------------------------------------------------------------

    fxp_resize #(
        .in_wi    (`FXP_WI + 1),
        .in_wf    (`FXP_WF)
    ) u_sum_resize (
        .in       (s1_raw[sum_w-1:0]),
        .round    (s1_round),
        .out      (sum_out),
        .overflow (sum_ovf)
    );

    fxp_resize #(
        .in_wi    (2 * `FXP_WI),
        .in_wf    (2 * `FXP_WF)
    ) u_prod_resize (
        .in       (s1_raw),
        .round    (s1_round),
        .out      (prod_out),
        .overflow (prod_ovf)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            res_valid <= 1'b0;
        else
            res_valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res_data <= (s1_opcode == OP_MUL) ? prod_out : sum_out;
            res_ovf  <= (s1_opcode == OP_MUL) ? prod_ovf : sum_ovf;
        end
    end

endmodule

/* logic/fxp_result.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

module fxp_result
    import fxp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    fxp_op_if.tracker op,
    input  logic      res_valid,
    input  fxp_t      res_data,
    input  logic      res_ovf,
    input  logic      ovf_clear,
    output fxp_t      result,
    output logic      done,
    output logic      ovf_sticky
);

    // up to three operations between issue and capture
    logic [1:0] in_flight;
    logic       landed;

    // ------------------------------------------------------------------------
    // in-flight tracking
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({op.valid, res_valid})
                2'b10:   in_flight <= in_flight + 2'd1;
                2'b01:   in_flight <= in_flight - 2'd1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // captured result and sticky overflow
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
            landed <= 1'b0;
        end else if (res_valid) begin
            // later results simply overwrite earlier ones
            result <= res_data;
            landed <= 1'b1;
        end
    end

    // a new overflow beats a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ovf_sticky <= 1'b0;
        else if (res_valid && res_ovf)
            ovf_sticky <= 1'b1;
        else if (ovf_clear)
            ovf_sticky <= 1'b0;
    end

    // the issue pulse drops done before the counter sees it
    assign done = landed && (in_flight == 2'd0) && !op.valid;

endmodule

/* logic/fxp_alu.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

module fxp_alu
    import fxp_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    logic res_valid;
    fxp_t res_data;
    logic res_ovf;
    fxp_t result;
    logic done;
    logic ovf_sticky;
    logic ovf_clear;

    fxp_op_if op_bus ();

    fxp_apb_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .op         (op_bus.issuer),
        .result     (result),
        .done       (done),
        .ovf_sticky (ovf_sticky),
        .ovf_clear  (ovf_clear)
    );

    fxp_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .op        (op_bus.worker),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_ovf   (res_ovf)
    );

    fxp_result u_result (
        .clk        (clk),
        .rst        (rst),
        .op         (op_bus.tracker),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_ovf    (res_ovf),
        .ovf_clear  (ovf_clear),
        .result     (result),
        .done       (done),
        .ovf_sticky (ovf_sticky)
    );

endmodule

/* verification/fxp_alu_asserts.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

module fxp_alu_asserts
    import fxp_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               psel,
    input logic               penable,
    input logic               pwrite,
    input logic [`APB_AW-1:0] paddr,
    input logic [31:0]        pwdata,
    input logic               pready,
    input logic               pslverr,
    input logic               res_valid,
    input logic               res_ovf,
    input fxp_t               result,
    input logic               done,
    input logic               ovf_sticky
);

    // CTRL write with a legal opcode, completing on this edge
    logic ctrl_issue;

    // number of assertion failures so far
    int   fail_count = 0;

    assign ctrl_issue = psel && penable && pwrite && (paddr == `REG_CTRL) &&
                        (pwdata[`CTRL_OP_LSB +: 2] != 2'd3);

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            $error("pready went low");
            fail_count++;
        end

    a_pslverr_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else begin
            $error("pslverr raised outside an access phase");
            fail_count++;
        end

    // valid is high one cycle later, so done drops from then on
    a_done_low_after_issue: assert property (@(posedge clk) disable iff (rst)
        ctrl_issue |=> ##1 !done)
        else begin
            $error("done high while an operation was being issued");
            fail_count++;
        end

    a_sat_sets_sticky: assert property (@(posedge clk) disable iff (rst)
        (res_valid && res_ovf) |=>
            (ovf_sticky && ((result == 16'h7FFF) || (result == 16'h8000))))
        else begin
            $error("saturated result without sticky overflow");
            fail_count++;
        end

endmodule

bind fxp_alu fxp_alu_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .res_valid  (res_valid),
    .res_ovf    (res_ovf),
    .result     (result),
    .done       (done),
    .ovf_sticky (ovf_sticky)
);

/* verification/fxp_alu_tb.sv */
`timescale 1ns/100ps
`include "fxp_defines.svh"

module fxp_alu_tb
    import fxp_pkg::*;
();

    localparam int poll_limit  = 20;
    localparam int ready_limit = 8;

    logic               clk;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;

    logic [15:0]        lfsr_state;
    logic               exp_sticky;
    fxp_t               exp_result;

    fxp_alu u_fxp_alu (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // one LFSR step for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // returns {overflow, result}
    function automatic logic [16:0] ref_calc(input fxp_opcode_e opc, input logic rnd,
                                             input fxp_t a, input fxp_t b);
        int prod;
        int kept;
        case (opc)
            OP_SUB: kept = int'(a) - int'(b);
            OP_MUL: begin
                prod = int'(a) * int'(b);
                kept = prod >>> `FXP_WF;
                // half-up on the first dropped bit, 16.16 kept value tops out at 0x7FFFFF
                if (rnd && prod[`FXP_WF-1] && (kept < 32'sh007F_FFFF))
                    kept = kept + 1;
            end
            default: kept = int'(a) + int'(b);
        endcase
        if (kept > 32767)
            return {1'b1, 16'h7FFF};
        if (kept < -32768)
            return {1'b1, 16'h8000};
        return {1'b0, kept[15:0]};
    endfunction

    // ------------------------------------------------------------------------
    // checking and bus tasks
    // ------------------------------------------------------------------------

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    // watch the bound assertions on the DUT
    always @(u_fxp_alu.u_asserts.fail_count) begin
        assert (u_fxp_alu.u_asserts.fail_count == 0) else begin
            $display("a bound assertion on the DUT failed");
            stop_with_failure();
        end
    end

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] gotv);
        assert (gotv === expv) else begin
            $display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expv, gotv);
            stop_with_failure();
        end
    endtask

    // starts 2 ns after a rising edge, ends at the same point after completion
    task automatic bus_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int waits;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > ready_limit) begin
                $display("APB transfer stalled, pready never came high");
                stop_with_failure();
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        bus_transfer(1'b1, addr, data, unused, err);
        check_value("pslverr", 32'd0, {31'd0, err});
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        bus_transfer(1'b0, addr, 32'd0, data, err);
        check_value("pslverr", 32'd0, {31'd0, err});
    endtask

    task automatic clear_sticky();
        apb_write(`REG_STATUS, 32'd1 << `STAT_OVF_BIT);
        exp_sticky = 1'b0;
    endtask

    // writes the operands and CTRL, and updates the expected state
    task automatic issue_op(input fxp_opcode_e opc, input logic rnd,
                            input fxp_t a, input fxp_t b);
        logic [16:0] expv;
        apb_write(`REG_OPA, {16'd0, a});
        apb_write(`REG_OPB, {16'd0, b});
        apb_write(`REG_CTRL, {29'd0, rnd, opc});
        expv       = ref_calc(opc, rnd, a, b);
        exp_result = expv[15:0];
        exp_sticky = exp_sticky | expv[16];
    endtask

    task automatic check_outcome();
        logic [31:0] status;
        logic [31:0] data;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[`STAT_DONE_BIT]) begin
            if (polls == poll_limit) begin
                $display("done never rose after %0d STATUS reads", poll_limit);
                stop_with_failure();
            end
            apb_read(`REG_STATUS, status);
            polls++;
        end
        apb_read(`REG_RESULT, data);
        check_value("RESULT", {{16{exp_result[15]}}, exp_result}, data);
        apb_read(`REG_STATUS, status);
        check_value("STATUS", {30'd0, exp_sticky, 1'b1}, status);
    endtask

    task automatic run_op(input fxp_opcode_e opc, input logic rnd,
                          input fxp_t a, input fxp_t b);
        issue_op(opc, rnd, a, b);
        check_outcome();
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        fxp_t        a;
        fxp_t        b;
        fxp_opcode_e opc;
        logic [31:0] data;
        logic        err;

        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 16'd22;
        exp_sticky = 1'b0;
        exp_result = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset values
        apb_read(`REG_STATUS, data);
        check_value("STATUS", 32'd0, data);
        apb_read(`REG_RESULT, data);
        check_value("RESULT", 32'd0, data);
        apb_read(`REG_OPA, data);
        check_value("OPA", 32'd0, data);
        apb_read(`REG_OPB, data);
        check_value("OPB", 32'd0, data);

        // add and subtract, saturating at both ends
        run_op(OP_ADD, 1'b0, 16'h7FFF, 16'h0001);
        clear_sticky();
        run_op(OP_SUB, 1'b0, 16'h8000, 16'h0001);
        clear_sticky();
        run_op(OP_ADD, 1'b1, 16'h8000, 16'h8000);
        for (int i = 0; i < 200; i++) begin
            clear_sticky();
            opc = rand_bits(1) ? OP_SUB : OP_ADD;
            a   = rand_bits(16);
            b   = rand_bits(16);
            run_op(opc, rand_bits(1), a, b);
        end

        // multiply, directed then random with narrowed operands
        clear_sticky();
        run_op(OP_MUL, 1'b0, 16'h0080, 16'h0080);
        run_op(OP_MUL, 1'b0, 16'h8000, 16'hFF00);
        clear_sticky();
        run_op(OP_MUL, 1'b0, 16'h0001, 16'h0080);
        run_op(OP_MUL, 1'b1, 16'h0001, 16'h0080);
        run_op(OP_MUL, 1'b1, 16'hFFFF, 16'h0080);
        for (int i = 0; i < 120; i++) begin
            clear_sticky();
            a = rand_bits(16);
            a = a >>> rand_bits(3);
            b = rand_bits(16);
            b = b >>> rand_bits(3);
            run_op(OP_MUL, rand_bits(1), a, b);
        end

        // sticky overflow survives clean operations until cleared
        clear_sticky();
        run_op(OP_ADD, 1'b0, 16'h7F00, 16'h0200);
        run_op(OP_ADD, 1'b0, 16'h0100, 16'h0100);
        clear_sticky();
        apb_read(`REG_STATUS, data);
        check_value("STATUS", 32'd1 << `STAT_DONE_BIT, data);

        // new operand, so a wrongly issued operation would change RESULT
        apb_write(`REG_OPA, 32'h0000_0300);

        // slave errors
        bus_transfer(1'b0, 8'h14, 32'd0, data, err);
        check_value("pslverr", 32'd1, {31'd0, err});
        bus_transfer(1'b1, `REG_CTRL, 32'd3, data, err);
        check_value("pslverr", 32'd1, {31'd0, err});
        repeat (3) begin
            apb_read(`REG_STATUS, data);
            check_value("STATUS", {30'd0, exp_sticky, 1'b1}, data);
        end
        apb_read(`REG_RESULT, data);
        check_value("RESULT", {{16{exp_result[15]}}, exp_result}, data);

        // three operations back to back, last result wins
        clear_sticky();
        issue_op(OP_MUL, 1'b0, 16'h4000, 16'h4000);
        issue_op(OP_ADD, 1'b0, 16'h0100, 16'h0200);
        issue_op(OP_SUB, 1'b1, 16'h0300, 16'h0080);
        check_outcome();
        for (int i = 0; i < 10; i++) begin
            clear_sticky();
            repeat (3) begin
                opc = fxp_opcode_e'(rand_bits(1) ? 2'd2 : rand_bits(1));
                a   = rand_bits(16);
                b   = rand_bits(16);
                b   = b >>> rand_bits(3);
                issue_op(opc, rand_bits(1), a, b);
            end
            check_outcome();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/fxp_pkg.sv
logic/fxp_op_if.sv
logic/fxp_resize.sv
logic/fxp_apb_decode.sv
logic/fxp_execute.sv
logic/fxp_result.sv
logic/fxp_alu.sv
verification/fxp_alu_asserts.sv
verification/fxp_alu_tb.sv
